//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/axi_bridge_pkg.sv
      - source/rw_arbiter.sv
      - source/axi_master_if.sv
      - source/axi_sram_slave.sv
      - source/mem_subsys_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_clk_gen.sv
      - verification/mem_subsys_tb.sv

//--- filelist.f
+incdir+source
source/axi_bridge_pkg.sv
source/rw_arbiter.sv
source/axi_master_if.sv
source/axi_sram_slave.sv
source/mem_subsys_top.sv
verification/tb_clk_gen.sv
verification/mem_subsys_tb.sv

//--- source/axi_bridge_cfg.svh
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// Bus widths shared by the rw port and AXI
`define RW_ADDR_WIDTH        64
`define RW_DATA_WIDTH        64
`define AXI_ID_WIDTH         4

// SRAM window, depth in 64-bit words
`define MEM_BASE             64'h8000_0000
`define MEM_WORDS            256

// Fixed AXI attribute encodings
`define AXI_BURST_INCR       2'b01
`define AXI_CACHE_DEV_NONBUF 4'b0000
`define AXI_PROT_UNPRIV      3'b000

`endif

//--- source/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_e;

    // Access size, log2 of the byte count
    typedef enum logic [2:0] {
        SZ_B = 3'd0,
        SZ_H = 3'd1,
        SZ_W = 3'd2,
        SZ_D = 3'd3
    } rw_size_e;

    // Which requester owns the rw port
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } req_src_e;

endpackage

//--- source/axi_master_if.sv
`timescale 1ns/1ps
`include "axi_bridge_cfg.svh"

module axi_master_if
    import axi_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // rw port
    input  req_src_e                      rw_id_i,
    input  logic                          rw_cen_i,
    input  logic                          rw_wen_i,
    input  logic [`RW_ADDR_WIDTH-1:0]     rw_addr_i,
    input  rw_size_e                      rw_size_i,
    input  logic [`RW_DATA_WIDTH-1:0]     rw_wdata_i,
    input  logic [`RW_DATA_WIDTH/8-1:0]   rw_wmask_i,
    output logic                          rw_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]     rw_rdata_o,
    output axi_resp_e                     rw_resp_o,
    // Write address
    output logic [`AXI_ID_WIDTH-1:0]      axi_aw_id_o,
    output logic [`RW_ADDR_WIDTH-1:0]     axi_aw_addr_o,
    output logic [7:0]                    axi_aw_len_o,
    output logic [2:0]                    axi_aw_size_o,
    output logic [1:0]                    axi_aw_burst_o,
    output logic [3:0]                    axi_aw_cache_o,
    output logic [2:0]                    axi_aw_prot_o,
    output logic                          axi_aw_valid_o,
    input  logic                          axi_aw_ready_i,
    // Write data
    input  logic                          axi_w_ready_i,
    output logic                          axi_w_valid_o,
    output logic [`RW_DATA_WIDTH-1:0]     axi_w_data_o,
    output logic [`RW_DATA_WIDTH/8-1:0]   axi_w_strb_o,
    output logic                          axi_w_last_o,
    // Write response
    output logic                          axi_b_ready_o,
    input  logic                          axi_b_valid_i,
    input  axi_resp_e                     axi_b_resp_i,
    input  logic [`AXI_ID_WIDTH-1:0]      axi_b_id_i,
    // Read address
    input  logic                          axi_ar_ready_i,
    output logic                          axi_ar_valid_o,
    output logic [`RW_ADDR_WIDTH-1:0]     axi_ar_addr_o,
    output logic [2:0]                    axi_ar_prot_o,
    output logic [`AXI_ID_WIDTH-1:0]      axi_ar_id_o,
    output logic [7:0]                    axi_ar_len_o,
    output logic [2:0]                    axi_ar_size_o,
    output logic [1:0]                    axi_ar_burst_o,
    output logic [3:0]                    axi_ar_cache_o,
    // Read data
    output logic                          axi_r_ready_o,
    input  logic                          axi_r_valid_i,
    input  axi_resp_e                     axi_r_resp_i,
    input  logic [`RW_DATA_WIDTH-1:0]     axi_r_data_i,
    input  logic                          axi_r_last_i,
    input  logic [`AXI_ID_WIDTH-1:0]      axi_r_id_i
);

    typedef enum logic [2:0] {W_IDLE, W_ADDR, W_WRITE, W_RESP, W_DONE} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_READ, R_DONE} r_state_e;

    w_state_e                    w_state;
    r_state_e                    r_state;
    logic                        wr_req;
    logic                        rd_req;
    logic                        aw_hs;
    logic                        w_hs;
    logic                        b_hs;
    logic                        ar_hs;
    logic                        r_hs;
    logic                        trans_done;
    axi_resp_e                   resp_next;
    logic [`AXI_ID_WIDTH-1:0]    axi_id;

    assign wr_req = rw_cen_i && rw_wen_i;
    assign rd_req = rw_cen_i && !rw_wen_i;

    assign aw_hs = axi_aw_valid_o && axi_aw_ready_i;
    assign w_hs  = axi_w_valid_o && axi_w_ready_i;
    assign b_hs  = axi_b_ready_o && axi_b_valid_i;
    assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
    assign r_hs  = axi_r_ready_o && axi_r_valid_i;

    assign trans_done = rw_wen_i ? b_hs : (r_hs && axi_r_last_i);
    assign resp_next  = rw_wen_i ? axi_b_resp_i : axi_r_resp_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_state <= W_IDLE;
        end else if (wr_req) begin
            case (w_state)
                W_IDLE:  w_state <= W_ADDR;
                W_ADDR:  if (aw_hs) w_state <= W_WRITE;
                W_WRITE: if (w_hs && axi_w_last_o) w_state <= W_RESP;
                W_RESP:  if (b_hs) w_state <= W_DONE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_state <= R_IDLE;
        end else if (rd_req) begin
            case (r_state)
                R_IDLE:  r_state <= R_ADDR;
                R_ADDR:  if (ar_hs) r_state <= R_READ;
                R_READ:  if (r_hs && axi_r_last_i) r_state <= R_DONE;
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // Requester source rides in the low id bit
    assign axi_id = {{(`AXI_ID_WIDTH-1){1'b0}}, rw_id_i};

    assign axi_aw_id_o    = axi_id;
    assign axi_aw_addr_o  = rw_addr_i;
    assign axi_aw_len_o   = 8'd0;
    assign axi_aw_size_o  = rw_size_i;
    assign axi_aw_burst_o = `AXI_BURST_INCR;
    assign axi_aw_cache_o = `AXI_CACHE_DEV_NONBUF;
    assign axi_aw_prot_o  = `AXI_PROT_UNPRIV;
    assign axi_aw_valid_o = (w_state == W_ADDR);

    // Single beat, so the only beat is the last
    assign axi_w_valid_o  = (w_state == W_WRITE);
    assign axi_w_data_o   = rw_wdata_i;
    assign axi_w_strb_o   = rw_wmask_i;
    assign axi_w_last_o   = (w_state == W_WRITE);
    assign axi_b_ready_o  = (w_state == W_RESP);

    assign axi_ar_id_o    = axi_id;
    assign axi_ar_addr_o  = rw_addr_i;
    assign axi_ar_len_o   = 8'd0;
    assign axi_ar_size_o  = rw_size_i;
    assign axi_ar_burst_o = `AXI_BURST_INCR;
    assign axi_ar_cache_o = `AXI_CACHE_DEV_NONBUF;
    assign axi_ar_prot_o  = `AXI_PROT_UNPRIV;
    assign axi_ar_valid_o = (r_state == R_ADDR);
    assign axi_r_ready_o  = (r_state == R_READ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rw_ready_o <= 1'b0;
            rw_resp_o  <= OKAY;
        end else begin
            rw_ready_o <= trans_done;
            rw_resp_o  <= trans_done ? resp_next : OKAY;
        end
    end

    // Read data held for the ready pulse
    always_ff @(posedge clk) begin
        if (r_hs) begin
            rw_rdata_o <= axi_r_data_i;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (axi_aw_valid_o && !axi_aw_ready_i) |=> axi_aw_valid_o);

    // Slave echoes the id of the requester that issued the access
    assert property (@(posedge clk) disable iff (!rst_n)
        b_hs |-> (axi_b_id_i == axi_aw_id_o));
    assert property (@(posedge clk) disable iff (!rst_n)
        r_hs |-> (axi_r_id_i == axi_ar_id_o));

endmodule

//--- source/axi_sram_slave.sv
`timescale 1ns/1ps
`include "axi_bridge_cfg.svh"

module axi_sram_slave
    import axi_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // Write address
    input  logic                          aw_valid_i,
    output logic                          aw_ready_o,
    input  logic [`RW_ADDR_WIDTH-1:0]     aw_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]      aw_id_i,
    // Write data
    input  logic                          w_valid_i,
    output logic                          w_ready_o,
    input  logic [`RW_DATA_WIDTH-1:0]     w_data_i,
    input  logic [`RW_DATA_WIDTH/8-1:0]   w_strb_i,
    input  logic                          w_last_i,
    // Write response
    output logic                          b_valid_o,
    input  logic                          b_ready_i,
    output axi_resp_e                     b_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]      b_id_o,
    // Read address
    input  logic                          ar_valid_i,
    output logic                          ar_ready_o,
    input  logic [`RW_ADDR_WIDTH-1:0]     ar_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]      ar_id_i,
    // Read data
    output logic                          r_valid_o,
    input  logic                          r_ready_i,
    output logic [`RW_DATA_WIDTH-1:0]     r_data_o,
    output axi_resp_e                     r_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]      r_id_o,
    output logic                          r_last_o
);

    localparam int IDX_W  = $clog2(`MEM_WORDS);
    localparam int STRB_W = `RW_DATA_WIDTH / 8;

    typedef enum logic [1:0] {S_IDLE, S_WDATA, S_BRESP, S_RDATA} state_e;

    state_e                       state;
    logic [`RW_DATA_WIDTH-1:0]    mem [`MEM_WORDS];
    logic [`RW_ADDR_WIDTH-1:0]    wr_addr_q;
    logic                         aw_hs;
    logic                         ar_hs;
    logic                         w_hs;
    logic                         wr_in_win;
    logic                         rd_in_win;
    logic [IDX_W-1:0]             wr_idx;
    logic [IDX_W-1:0]             rd_idx;

    function automatic logic in_window(input logic [`RW_ADDR_WIDTH-1:0] addr);
        logic [`RW_ADDR_WIDTH-1:0] offs;
        offs = addr - `MEM_BASE;
        return (addr >= `MEM_BASE) && ((offs >> 3) < `MEM_WORDS);
    endfunction

    // Byte offset from the window base, in words
    function automatic logic [IDX_W-1:0] word_idx(input logic [`RW_ADDR_WIDTH-1:0] addr);
        logic [`RW_ADDR_WIDTH-1:0] offs;
        offs = addr - `MEM_BASE;
        return offs[3 +: IDX_W];
    endfunction

    assign aw_ready_o = (state == S_IDLE);
    // Write address takes precedence when both arrive together
    assign ar_ready_o = (state == S_IDLE) && !aw_valid_i;
    assign w_ready_o  = (state == S_WDATA);
    assign b_valid_o  = (state == S_BRESP);
    assign r_valid_o  = (state == S_RDATA);
    assign r_last_o   = (state == S_RDATA);

    assign aw_hs = aw_valid_i && aw_ready_o;
    assign ar_hs = ar_valid_i && ar_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;

    assign wr_in_win = in_window(wr_addr_q);
    assign wr_idx    = word_idx(wr_addr_q);
    assign rd_in_win = in_window(ar_addr_i);
    assign rd_idx    = word_idx(ar_addr_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_hs) state <= S_WDATA;
                    else if (ar_hs) state <= S_RDATA;
                end
                S_WDATA: if (w_hs) state <= S_BRESP;
                S_BRESP: if (b_ready_i) state <= S_IDLE;
                default: if (r_ready_i) state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_addr_q <= aw_addr_i;
            b_id_o    <= aw_id_i;
        end
        if (w_hs) begin
            b_resp_o <= wr_in_win ? OKAY : SLVERR;
        end
        // Out-of-window reads return zero data
        if (ar_hs) begin
            r_data_o <= rd_in_win ? mem[rd_idx] : '0;
            r_resp_o <= rd_in_win ? OKAY : SLVERR;
            r_id_o   <= ar_id_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (w_hs && wr_in_win) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (w_strb_i[b]) begin
                    mem[wr_idx][b*8 +: 8] <= w_data_i[b*8 +: 8];
                end
            end
        end
    end

    // Master only issues single-beat writes
    assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> w_last_i);

endmodule

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps
`include "axi_bridge_cfg.svh"

module mem_subsys_top
    import axi_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // Fetch port
    input  logic                          if_req_i,
    input  logic [`RW_ADDR_WIDTH-1:0]     if_addr_i,
    output logic                          if_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]     if_rdata_o,
    output axi_resp_e                     if_resp_o,
    // Data port
    input  logic                          d_req_i,
    input  logic                          d_we_i,
    input  logic [`RW_ADDR_WIDTH-1:0]     d_addr_i,
    input  rw_size_e                      d_size_i,
    input  logic [`RW_DATA_WIDTH-1:0]     d_wdata_i,
    input  logic [`RW_DATA_WIDTH/8-1:0]   d_wmask_i,
    output logic                          d_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]     d_rdata_o,
    output axi_resp_e                     d_resp_o
);

    // rw bus
    logic                          rw_cen;
    logic                          rw_wen;
    req_src_e                      rw_id;
    logic [`RW_ADDR_WIDTH-1:0]     rw_addr;
    rw_size_e                      rw_size;
    logic [`RW_DATA_WIDTH-1:0]     rw_wdata;
    logic [`RW_DATA_WIDTH/8-1:0]   rw_wmask;
    logic                          rw_ready;
    logic [`RW_DATA_WIDTH-1:0]     rw_rdata;
    axi_resp_e                     rw_resp;

    // AXI channels
    logic                          aw_valid;
    logic                          aw_ready;
    logic [`RW_ADDR_WIDTH-1:0]     aw_addr;
    logic [`AXI_ID_WIDTH-1:0]      aw_id;
    logic                          w_valid;
    logic                          w_ready;
    logic [`RW_DATA_WIDTH-1:0]     w_data;
    logic [`RW_DATA_WIDTH/8-1:0]   w_strb;
    logic                          w_last;
    logic                          b_valid;
    logic                          b_ready;
    axi_resp_e                     b_resp;
    logic [`AXI_ID_WIDTH-1:0]      b_id;
    logic                          ar_valid;
    logic                          ar_ready;
    logic [`RW_ADDR_WIDTH-1:0]     ar_addr;
    logic [`AXI_ID_WIDTH-1:0]      ar_id;
    logic                          r_valid;
    logic                          r_ready;
    logic [`RW_DATA_WIDTH-1:0]     r_data;
    axi_resp_e                     r_resp;
    logic [`AXI_ID_WIDTH-1:0]      r_id;
    logic                          r_last;

    rw_arbiter rw_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_req_i   (if_req_i),
        .if_addr_i  (if_addr_i),
        .if_ready_o (if_ready_o),
        .if_rdata_o (if_rdata_o),
        .if_resp_o  (if_resp_o),
        .d_req_i    (d_req_i),
        .d_we_i     (d_we_i),
        .d_addr_i   (d_addr_i),
        .d_size_i   (d_size_i),
        .d_wdata_i  (d_wdata_i),
        .d_wmask_i  (d_wmask_i),
        .d_ready_o  (d_ready_o),
        .d_rdata_o  (d_rdata_o),
        .d_resp_o   (d_resp_o),
        .rw_cen_o   (rw_cen),
        .rw_wen_o   (rw_wen),
        .rw_id_o    (rw_id),
        .rw_addr_o  (rw_addr),
        .rw_size_o  (rw_size),
        .rw_wdata_o (rw_wdata),
        .rw_wmask_o (rw_wmask),
        .rw_ready_i (rw_ready),
        .rw_rdata_i (rw_rdata),
        .rw_resp_i  (rw_resp)
    );

    // Fixed AXI attributes are not used by the SRAM
    axi_master_if axi_master_if_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .rw_id_i        (rw_id),
        .rw_cen_i       (rw_cen),
        .rw_wen_i       (rw_wen),
        .rw_addr_i      (rw_addr),
        .rw_size_i      (rw_size),
        .rw_wdata_i     (rw_wdata),
        .rw_wmask_i     (rw_wmask),
        .rw_ready_o     (rw_ready),
        .rw_rdata_o     (rw_rdata),
        .rw_resp_o      (rw_resp),
        .axi_aw_id_o    (aw_id),
        .axi_aw_addr_o  (aw_addr),
        .axi_aw_len_o   (),
        .axi_aw_size_o  (),
        .axi_aw_burst_o (),
        .axi_aw_cache_o (),
        .axi_aw_prot_o  (),
        .axi_aw_valid_o (aw_valid),
        .axi_aw_ready_i (aw_ready),
        .axi_w_ready_i  (w_ready),
        .axi_w_valid_o  (w_valid),
        .axi_w_data_o   (w_data),
        .axi_w_strb_o   (w_strb),
        .axi_w_last_o   (w_last),
        .axi_b_ready_o  (b_ready),
        .axi_b_valid_i  (b_valid),
        .axi_b_resp_i   (b_resp),
        .axi_b_id_i     (b_id),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_prot_o  (),
        .axi_ar_id_o    (ar_id),
        .axi_ar_len_o   (),
        .axi_ar_size_o  (),
        .axi_ar_burst_o (),
        .axi_ar_cache_o (),
        .axi_r_ready_o  (r_ready),
        .axi_r_valid_i  (r_valid),
        .axi_r_resp_i   (r_resp),
        .axi_r_data_i   (r_data),
        .axi_r_last_i   (r_last),
        .axi_r_id_i     (r_id)
    );

    axi_sram_slave axi_sram_slave_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .aw_addr_i  (aw_addr),
        .aw_id_i    (aw_id),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .w_last_i   (w_last),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .b_resp_o   (b_resp),
        .b_id_o     (b_id),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .ar_id_i    (ar_id),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_id_o     (r_id),
        .r_last_o   (r_last)
    );

endmodule

//--- source/rw_arbiter.sv
`timescale 1ns/1ps
`include "axi_bridge_cfg.svh"

module rw_arbiter
    import axi_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // Fetch port
    input  logic                          if_req_i,
    input  logic [`RW_ADDR_WIDTH-1:0]     if_addr_i,
    output logic                          if_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]     if_rdata_o,
    output axi_resp_e                     if_resp_o,
    // Data port
    input  logic                          d_req_i,
    input  logic                          d_we_i,
    input  logic [`RW_ADDR_WIDTH-1:0]     d_addr_i,
    input  rw_size_e                      d_size_i,
    input  logic [`RW_DATA_WIDTH-1:0]     d_wdata_i,
    input  logic [`RW_DATA_WIDTH/8-1:0]   d_wmask_i,
    output logic                          d_ready_o,
    output logic [`RW_DATA_WIDTH-1:0]     d_rdata_o,
    output axi_resp_e                     d_resp_o,
    // Shared rw port
    output logic                          rw_cen_o,
    output logic                          rw_wen_o,
    output req_src_e                      rw_id_o,
    output logic [`RW_ADDR_WIDTH-1:0]     rw_addr_o,
    output rw_size_e                      rw_size_o,
    output logic [`RW_DATA_WIDTH-1:0]     rw_wdata_o,
    output logic [`RW_DATA_WIDTH/8-1:0]   rw_wmask_o,
    input  logic                          rw_ready_i,
    input  logic [`RW_DATA_WIDTH-1:0]     rw_rdata_i,
    input  axi_resp_e                     rw_resp_i
);

    logic     busy_q;
    req_src_e gnt_q;
    logic     data_gnt;

    // Data port wins a tie, grant held until the rw port finishes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            gnt_q  <= SRC_FETCH;
        end else if (!busy_q) begin
            if (d_req_i || if_req_i) begin
                busy_q <= 1'b1;
                gnt_q  <= d_req_i ? SRC_DATA : SRC_FETCH;
            end
        end else if (rw_ready_i) begin
            busy_q <= 1'b0;
        end
    end

    assign data_gnt   = (gnt_q == SRC_DATA);

    assign rw_cen_o   = busy_q;
    assign rw_id_o    = gnt_q;
    // Fetch is always a full-word read
    assign rw_wen_o   = data_gnt && d_we_i;
    assign rw_addr_o  = data_gnt ? d_addr_i : if_addr_i;
    assign rw_size_o  = data_gnt ? d_size_i : SZ_D;
    assign rw_wdata_o = data_gnt ? d_wdata_i : '0;
    assign rw_wmask_o = data_gnt ? d_wmask_i : '0;

    assign if_ready_o = rw_ready_i && !data_gnt;
    assign if_rdata_o = rw_rdata_i;
    assign if_resp_o  = rw_resp_i;
    assign d_ready_o  = rw_ready_i && data_gnt;
    assign d_rdata_o  = rw_rdata_i;
    assign d_resp_o   = rw_resp_i;

    // Owner of an open transfer never changes under the master
    assert property (@(posedge clk) disable iff (!rst_n)
        (busy_q && !rw_ready_i) |=> (busy_q && $stable(gnt_q)));

endmodule

//--- verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "axi_bridge_cfg.svh"

module mem_subsys_tb
    import axi_bridge_pkg::*;
();

    localparam int WAIT_LIMIT  = 40;
    localparam int RESET_LIMIT = 40;

    typedef struct packed {
        logic [`RW_DATA_WIDTH-1:0] rdata;
        axi_resp_e                 resp;
        logic                      is_read;
    } exp_t;

    logic                          clk;
    logic                          rst_n;
    logic                          if_req;
    logic [`RW_ADDR_WIDTH-1:0]     if_addr;
    logic                          if_ready;
    logic [`RW_DATA_WIDTH-1:0]     if_rdata;
    axi_resp_e                     if_resp;
    logic                          d_req;
    logic                          d_we;
    logic [`RW_ADDR_WIDTH-1:0]     d_addr;
    rw_size_e                      d_size;
    logic [`RW_DATA_WIDTH-1:0]     d_wdata;
    logic [`RW_DATA_WIDTH/8-1:0]   d_wmask;
    logic                          d_ready;
    logic [`RW_DATA_WIDTH-1:0]     d_rdata;
    axi_resp_e                     d_resp;

    // Mirror of the SRAM contents
    logic [`RW_DATA_WIDTH-1:0]     mirror [`MEM_WORDS];
    exp_t                          d_exp_q [$];
    exp_t                          f_exp_q [$];
    integer                        seed;

    tb_clk_gen tb_clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_subsys_top mem_subsys_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_req_i   (if_req),
        .if_addr_i  (if_addr),
        .if_ready_o (if_ready),
        .if_rdata_o (if_rdata),
        .if_resp_o  (if_resp),
        .d_req_i    (d_req),
        .d_we_i     (d_we),
        .d_addr_i   (d_addr),
        .d_size_i   (d_size),
        .d_wdata_i  (d_wdata),
        .d_wmask_i  (d_wmask),
        .d_ready_o  (d_ready),
        .d_rdata_o  (d_rdata),
        .d_resp_o   (d_resp)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            report_failure("stopping at first mismatch");
        end
    endtask

    function automatic logic [`RW_ADDR_WIDTH-1:0] word_addr(input int unsigned idx);
        return `MEM_BASE + 64'(idx) * 8;
    endfunction

    // Expected response for one access and the mirror update of a write
    function automatic void ref_access(input logic we, input logic [63:0] addr,
                                       input logic [63:0] wdata, input logic [7:0] wmask,
                                       output logic [63:0] rdata, output axi_resp_e resp);
        logic        in_win;
        logic [63:0] idx;
        in_win = (addr >= `MEM_BASE) && (addr < `MEM_BASE + `MEM_WORDS * 8);
        idx    = (addr - `MEM_BASE) / 8;
        rdata  = '0;
        resp   = in_win ? OKAY : SLVERR;
        if (in_win && we) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask[b]) mirror[idx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end else if (in_win) begin
            rdata = mirror[idx];
        end
    endfunction

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_LIMIT) report_failure("reset was never released");
        end
    endtask

    task automatic data_access(input logic we, input logic [63:0] addr,
                               input logic [63:0] wdata, input logic [7:0] wmask);
        exp_t entry;
        int   cycles;
        @(negedge clk);
        ref_access(we, addr, wdata, wmask, entry.rdata, entry.resp);
        entry.is_read = !we;
        d_exp_q.push_back(entry);
        d_we    = we;
        d_addr  = addr;
        d_wdata = wdata;
        d_wmask = wmask;
        d_size  = SZ_D;
        d_req   = 1'b1;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!d_ready && cycles > WAIT_LIMIT) report_failure("data port timed out");
        end while (!d_ready);
        d_req = 1'b0;
    endtask

    task automatic fetch_access(input logic [63:0] addr);
        exp_t entry;
        int   cycles;
        @(negedge clk);
        ref_access(1'b0, addr, '0, '0, entry.rdata, entry.resp);
        entry.is_read = 1'b1;
        f_exp_q.push_back(entry);
        if_addr = addr;
        if_req  = 1'b1;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!if_ready && cycles > WAIT_LIMIT) report_failure("fetch port timed out");
        end while (!if_ready);
        if_req = 1'b0;
    endtask

    // Both ports raise req together and the data port must finish first
    task automatic race_data_fetch(input logic we, input logic [63:0] addr,
                                   input logic [63:0] wdata, input logic [7:0] wmask,
                                   input logic [63:0] f_addr);
        exp_t d_entry;
        exp_t f_entry;
        logic d_done;
        logic f_done;
        int   cycles;
        @(negedge clk);
        ref_access(we, addr, wdata, wmask, d_entry.rdata, d_entry.resp);
        d_entry.is_read = !we;
        ref_access(1'b0, f_addr, '0, '0, f_entry.rdata, f_entry.resp);
        f_entry.is_read = 1'b1;
        d_exp_q.push_back(d_entry);
        f_exp_q.push_back(f_entry);
        d_we    = we;
        d_addr  = addr;
        d_wdata = wdata;
        d_wmask = wmask;
        d_size  = SZ_D;
        if_addr = f_addr;
        d_req   = 1'b1;
        if_req  = 1'b1;
        d_done  = 1'b0;
        f_done  = 1'b0;
        cycles  = 0;
        while (!(d_done && f_done)) begin
            @(negedge clk);
            cycles++;
            if (d_ready) begin
                d_req  = 1'b0;
                d_done = 1'b1;
            end
            if (if_ready) begin
                if (!d_done) report_failure("fetch port finished before data port");
                if_req = 1'b0;
                f_done = 1'b1;
            end
            if (cycles > 2 * WAIT_LIMIT) begin
                if (!d_done) report_failure("data port timed out with fetch pending");
                else report_failure("fetch port timed out after data finished");
            end
        end
    endtask

    task automatic wait_checks_drained();
        int cycles;
        cycles = 0;
        while (d_exp_q.size() != 0 || f_exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) report_failure("responses still missing at end of test");
        end
    endtask

    // Compares every ready pulse against the oldest expected entry
    initial begin : response_checker
        exp_t entry;
        forever begin
            @(negedge clk);
            if (rst_n && d_ready) begin
                if (d_exp_q.size() == 0) begin
                    report_failure("data port gave ready with no request open");
                end else begin
                    entry = d_exp_q.pop_front();
                    check_value("d_resp_o", d_resp, entry.resp);
                    if (entry.is_read) check_value("d_rdata_o", d_rdata, entry.rdata);
                end
            end
            if (rst_n && if_ready) begin
                if (f_exp_q.size() == 0) begin
                    report_failure("fetch port gave ready with no request open");
                end else begin
                    entry = f_exp_q.pop_front();
                    check_value("if_resp_o", if_resp, entry.resp);
                    check_value("if_rdata_o", if_rdata, entry.rdata);
                end
            end
        end
    end

    initial begin : stimulus
        logic [63:0] data;
        logic [63:0] bad_addr [4];
        integer      rnd;
        int unsigned idx;
        if_req     = 1'b0;
        if_addr    = '0;
        d_req      = 1'b0;
        d_we       = 1'b0;
        d_addr     = '0;
        d_size     = SZ_D;
        d_wdata    = '0;
        d_wmask    = '0;
        seed       = 32'h8273_48fb;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mirror[i] = '0;
        end
        wait_for_reset();

        // Quiet ports after reset
        repeat (5) begin
            @(negedge clk);
            check_value("if_ready_o", if_ready, '0);
            check_value("d_ready_o", d_ready, '0);
        end

        data = {$random(seed), $random(seed)};
        data_access(1'b1, word_addr(5), data, 8'hff);
        data_access(1'b0, word_addr(5), '0, 8'h00);

        // Partial strobes
        repeat (12) begin
            idx  = $unsigned($random(seed)) % `MEM_WORDS;
            data = {$random(seed), $random(seed)};
            rnd  = $random(seed);
            data_access(1'b1, word_addr(idx), data, rnd[7:0]);
            data_access(1'b0, word_addr(idx), '0, 8'h00);
        end

        // Words 0 and the last word catch an out-of-window index that wraps
        bad_addr[0] = `MEM_BASE - 8;
        bad_addr[1] = `MEM_BASE + `MEM_WORDS * 8;
        bad_addr[2] = 64'h0;
        bad_addr[3] = 64'hffff_ffff_ffff_fff8;
        data_access(1'b1, word_addr(0), 64'h0123_4567_89ab_cdef, 8'hff);
        data_access(1'b1, word_addr(`MEM_WORDS - 1), 64'hfedc_ba98_7654_3210, 8'hff);
        for (int i = 0; i < 4; i++) begin
            data = {$random(seed), $random(seed)};
            data_access(1'b1, bad_addr[i], data, 8'hff);
            data_access(1'b0, bad_addr[i], '0, 8'h00);
        end
        data_access(1'b0, word_addr(0), '0, 8'h00);
        data_access(1'b0, word_addr(`MEM_WORDS - 1), '0, 8'h00);

        fetch_access(word_addr(5));
        fetch_access(word_addr(0));
        repeat (6) begin
            idx = $unsigned($random(seed)) % `MEM_WORDS;
            fetch_access(word_addr(idx));
        end

        race_data_fetch(1'b0, word_addr(0), '0, 8'h00, word_addr(`MEM_WORDS - 1));
        // Fetch of the same word sees the data port's write
        data = {$random(seed), $random(seed)};
        race_data_fetch(1'b1, word_addr(7), data, 8'hff, word_addr(7));

        wait_checks_drained();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
